// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
logic/cpu_pkg.sv
logic/mem_program.sv
logic/reg_program_counter.sv
logic/mem_register.sv
logic/control_main.sv
logic/alu.sv
logic/hazard_detection_unit.sv
logic/cpu_top.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv

// File: logic/alu.sv
module alu (
	input  cpu_pkg::ex_ctrl_t ctrl,
	input  cpu_pkg::word_t    a,
	input  cpu_pkg::word_t    b,
	output cpu_pkg::word_t    result,
	output logic              equal
);
	import cpu_pkg::*;

	// Register-register result
	word_t op_result;

	always_comb begin
		case (ctrl.alu_ctrl)
			ADD:     op_result = a + b;
			SUB:     op_result = a - b;
			AND:     op_result = a & b;
			OR:      op_result = a | b;
			XOR:     op_result = a ^ b;
			// Single-bit shifts of the A operand
			SHL1:    op_result = a << 1;
			SHR1:    op_result = a >> 1;
			PASS_B:  op_result = b;
			default: op_result = '0;
		endcase
	end

	// Load-immediate bypasses the operators
	always_comb begin
		case (ctrl.opcode)
			OP_ALU:  result = op_result;
			OP_LI:   result = ctrl.imm;
			default: result = '0;
		endcase
	end

	// Skip-if-equal compare on the forwarded operands
	assign equal = (a == b);

endmodule

// File: logic/control_main.sv
module control_main (
	input  cpu_pkg::instr_t   instruction,
	output cpu_pkg::ex_ctrl_t ctrl,
	output logic              halt_req
);
	import cpu_pkg::*;

	// Raw instruction fields
	opcode_t   opcode;
	alu_ctrl_e func;
	logic      func_ok;

	assign opcode = opcode_t'(instruction[15:12]);
	assign func = alu_ctrl_e'(instruction[3:0]);

	// Only the eight defined functions are legal ALU ops
	always_comb begin
		case (func)
			ADD, SUB, AND, OR, XOR, SHL1, SHR1, PASS_B: func_ok = 1'b1;
			default: func_ok = 1'b0;
		endcase
	end

	always_comb begin
		// Fields are passed through for every opcode
		ctrl.opcode = opcode;
		ctrl.alu_ctrl = func;
		ctrl.dest = instruction[11:8];
		ctrl.r1 = instruction[11:8];
		ctrl.r2 = instruction[7:4];
		// Sign extend the low byte for load-immediate
		ctrl.imm = {{(WORD_W-IMM_W){instruction[IMM_W-1]}}, instruction[IMM_W-1:0]};
		ctrl.valid = 1'b0;

		case (opcode)
			OP_ALU: begin
				ctrl.valid = func_ok;
			end
			OP_LI: begin
				ctrl.valid = 1'b1;
			end
			OP_SKEQ: begin
				ctrl.valid = 1'b1;
			end
			// NOP, HALT and anything undefined leave a bubble
			default: begin
				ctrl.valid = 1'b0;
			end
		endcase
	end

	// Halt is acted on at fetch, not in execute
	assign halt_req = (opcode == OP_HALT);

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

	// Datapath width
	localparam int WORD_W = 16;
	// Register file sizing
	localparam int REG_AW = 4;
	localparam int NUM_REGS = 1 << REG_AW;
	// Program store sizing, in instruction words
	localparam int PROG_DEPTH = 256;
	localparam int PROG_AW = $clog2(PROG_DEPTH);
	// PC moves in bytes, one instruction is two bytes
	localparam int PC_STEP = 2;
	// Load-immediate field width
	localparam int IMM_W = 8;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [WORD_W-1:0] uword;
	typedef logic [WORD_W-1:0] instr_t;
	typedef logic [REG_AW-1:0] reg_addr_t;
	typedef logic [PROG_AW-1:0] prog_addr_t;

	// Major opcode in instruction bits 15..12
	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ALU  = 4'h1,
		OP_LI   = 4'h2,
		OP_SKEQ = 4'h3,
		OP_HALT = 4'hf
	} opcode_t;

	// ALU function, same encoding as the func field in bits 3..0
	typedef enum logic [3:0] {
		ADD    = 4'h0,
		SUB    = 4'h1,
		AND    = 4'h2,
		OR     = 4'h3,
		XOR    = 4'h4,
		SHL1   = 4'h5,
		SHR1   = 4'h6,
		PASS_B = 4'h7
	} alu_ctrl_e;

	// Decode to execute
	typedef struct packed {
		logic      valid;
		opcode_t   opcode;
		alu_ctrl_e alu_ctrl;
		reg_addr_t dest;
		reg_addr_t r1;
		reg_addr_t r2;
		word_t     imm;
	} ex_ctrl_t;

	// Register write-back, valid only for instructions that write
	typedef struct packed {
		logic      valid;
		reg_addr_t addr;
		word_t     data;
	} wb_t;

	// Empty execute slot
	localparam ex_ctrl_t EX_BUBBLE = '{
		valid:    1'b0,
		opcode:   OP_NOP,
		alu_ctrl: ADD,
		default:  '0
	};

endpackage

// File: logic/cpu_top.sv
module cpu_top (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                prog_we,
	input  cpu_pkg::prog_addr_t prog_addr,
	input  cpu_pkg::instr_t     prog_data,
	output cpu_pkg::wb_t        wb,
	output logic                halted,
	output cpu_pkg::uword       pc
);
	import cpu_pkg::*;

	// Fetch and decode
	uword     pc_addr;
	instr_t   instruction;
	ex_ctrl_t dec_ctrl;
	logic     halt_req;
	word_t    rd1;
	word_t    rd2;

	// Stage A, execute inputs
	ex_ctrl_t ex_q;
	word_t    a_q;
	word_t    b_q;

	// Execute
	word_t    op_a;
	word_t    op_b;
	word_t    alu_result;
	logic     alu_equal;
	logic     skip_taken;
	wb_t      wb_next;

	// Stage B and halt control
	wb_t      wb_q;
	logic     halted_q;
	logic     halt_take;
	logic     pc_hold;

	mem_program program_memory (
		.clk        (clk),
		.prog_we    (prog_we),
		.prog_addr  (prog_addr),
		.prog_data  (prog_data),
		.address    (pc_addr),
		.instruction(instruction)
	);

	reg_program_counter pc_reg (
		.clk        (clk),
		.arst_n     (arst_n),
		.halt       (pc_hold),
		.out_address(pc_addr)
	);

	control_main control_unit (
		.instruction(instruction),
		.ctrl       (dec_ctrl),
		.halt_req   (halt_req)
	);

	// Write port driven from stage B
	mem_register register_file (
		.clk   (clk),
		.arst_n(arst_n),
		.ra1   (dec_ctrl.r1),
		.ra2   (dec_ctrl.r2),
		.wb    (wb_q),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	hazard_detection_unit hdu (
		.ctrl   (ex_q),
		.a_reg  (a_q),
		.b_reg  (b_q),
		.stage_b(wb_q),
		.a      (op_a),
		.b      (op_b)
	);

	alu main_alu (
		.ctrl  (ex_q),
		.a     (op_a),
		.b     (op_b),
		.result(alu_result),
		.equal (alu_equal)
	);

	// Taken skip kills the instruction now in fetch
	assign skip_taken = ex_q.valid && (ex_q.opcode == OP_SKEQ) && alu_equal;

	// An annulled HALT is ignored
	assign halt_take = halt_req && !skip_taken;
	assign pc_hold = halted_q || halt_take;

	// Only ALU and load-immediate write back
	assign wb_next.valid = ex_q.valid && ((ex_q.opcode == OP_ALU) || (ex_q.opcode == OP_LI));
	assign wb_next.addr = ex_q.dest;
	assign wb_next.data = alu_result;

	// Stage A control, bubble on skip or once halted
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_q <= EX_BUBBLE;
		end else if (skip_taken || halted_q) begin
			ex_q <= EX_BUBBLE;
		end else begin
			ex_q <= dec_ctrl;
		end
	end

	// Stage A operands
	always_ff @(posedge clk) begin
		a_q <= rd1;
		b_q <= rd2;
	end

	// Stage B
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_q <= '0;
		end else begin
			wb_q <= wb_next;
		end
	end

	// Sticky until reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			halted_q <= 1'b0;
		end else if (halt_take) begin
			halted_q <= 1'b1;
		end
	end

	assign wb = wb_q;
	assign halted = halted_q;
	assign pc = pc_addr;

endmodule

// File: logic/hazard_detection_unit.sv
module hazard_detection_unit (
	input  cpu_pkg::ex_ctrl_t ctrl,
	input  cpu_pkg::word_t    a_reg,
	input  cpu_pkg::word_t    b_reg,
	input  cpu_pkg::wb_t      stage_b,
	output cpu_pkg::word_t    a,
	output cpu_pkg::word_t    b
);

	// Forward select per source
	logic fwd_a;
	logic fwd_b;

	// Stage B holds the result of the instruction right ahead
	// Its valid already means a register is written
	assign fwd_a = stage_b.valid && (stage_b.addr == ctrl.r1);
	assign fwd_b = stage_b.valid && (stage_b.addr == ctrl.r2);

	// Older results came through the register file write-through
	assign a = fwd_a ? stage_b.data : a_reg;
	assign b = fwd_b ? stage_b.data : b_reg;

endmodule

// File: logic/mem_program.sv
module mem_program (
	input  logic                clk,
	input  logic                prog_we,
	input  cpu_pkg::prog_addr_t prog_addr,
	input  cpu_pkg::instr_t     prog_data,
	input  cpu_pkg::uword       address,
	output cpu_pkg::instr_t     instruction
);
	import cpu_pkg::*;

	// Instruction store, contents survive reset
	instr_t mem [PROG_DEPTH];

	// Byte address to word index
	prog_addr_t rd_index;

	assign rd_index = address[PROG_AW:1];

	// Loader port, usable while the core sits in reset
	always_ff @(posedge clk) begin
		if (prog_we) begin
			mem[prog_addr] <= prog_data;
		end
	end

	// Asynchronous fetch so decode happens in the same cycle
	assign instruction = mem[rd_index];

endmodule

// File: logic/mem_register.sv
module mem_register (
	input  logic               clk,
	input  logic               arst_n,
	input  cpu_pkg::reg_addr_t ra1,
	input  cpu_pkg::reg_addr_t ra2,
	input  cpu_pkg::wb_t       wb,
	output cpu_pkg::word_t     rd1,
	output cpu_pkg::word_t     rd2
);
	import cpu_pkg::*;

	word_t regs [NUM_REGS];

	// Bypass hit flags for each read port
	logic hit1;
	logic hit2;

	// Single write port fed by the write-back stage
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// Same-cycle write is visible to the reader
	assign hit1 = wb.valid && (wb.addr == ra1);
	assign hit2 = wb.valid && (wb.addr == ra2);

	// Read port 1, first register field
	assign rd1 = hit1 ? wb.data : regs[ra1];
	// Read port 2, second register field
	assign rd2 = hit2 ? wb.data : regs[ra2];

endmodule

// File: logic/reg_program_counter.sv
module reg_program_counter (
	input  logic          clk,
	input  logic          arst_n,
	input  logic          halt,
	output cpu_pkg::uword out_address
);
	import cpu_pkg::*;

	// Sequential next address
	uword next_address;

	assign next_address = out_address + uword'(PC_STEP);

	// Advance one instruction per cycle
	// Halt freezes the PC at the halt instruction
	// A skip needs no extra offset, the annulled slot still consumed a step
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_address <= '0;
		end else if (!halt) begin
			out_address <= next_address;
		end
	end

endmodule

// File: testbench/cpu_checker.sv
module cpu_checker (
	input logic          clk,
	input logic          arst_n,
	input cpu_pkg::wb_t  wb,
	input logic          halted,
	input cpu_pkg::uword pc
);
	import cpu_pkg::*;

	// Tally of failed properties
	int failures = 0;

	// Write-back stage stays empty in reset
	reset_quiet: assert property (@(posedge clk) !arst_n |-> !wb.valid)
		else begin failures++; $error("wb.valid high during reset"); end

	// Byte PC, instructions are two bytes
	pc_even: assert property (@(posedge clk) pc[0] == 1'b0)
		else begin failures++; $error("pc is odd"); end

	// Only sequential steps
	pc_step: assert property (@(posedge clk) disable iff (!arst_n)
		(pc != $past(pc)) |-> (pc == $past(pc) + 16'd2))
		else begin failures++; $error("pc moved by something other than +2"); end

	// Halt holds until the next reset
	halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
		$past(halted) |-> halted)
		else begin failures++; $error("halted dropped without reset"); end

	pc_frozen: assert property (@(posedge clk) disable iff (!arst_n)
		halted |-> $stable(pc))
		else begin failures++; $error("pc changed while halted"); end

	// Pipeline drained by the third halted cycle
	halt_drained: assert property (@(posedge clk) disable iff (!arst_n)
		(halted && $past(halted, 2)) |-> !wb.valid)
		else begin failures++; $error("write-back after the pipeline drained"); end

endmodule

bind cpu_top cpu_checker checker_i (
	.clk   (clk),
	.arst_n(arst_n),
	.wb    (wb),
	.halted(halted),
	.pc    (pc)
);

// File: testbench/cpu_tb.sv
module cpu_tb;
	import cpu_pkg::*;

	logic       clk;
	logic       arst_n;
	logic       prog_we;
	prog_addr_t prog_addr;
	instr_t     prog_data;
	wb_t        wb;
	logic       halted;
	uword       pc;

	// Program image and reference write-backs
	instr_t prog [$];
	wb_t    expected [$];
	// Written only by the monitor
	int     seen = 0;
	int     wb_errors = 0;
	// Monitor index of the first write-back of this test
	int     base = 0;
	int     seed;
	int     errors;
	int     tests_run;

	cpu_top cpu_top_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.prog_we  (prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.wb       (wb),
		.halted   (halted),
		.pc       (pc)
	);

	always #5 clk = ~clk;

	// Opcode, first register, low byte (imm or r2 and func)
	function automatic instr_t encode(opcode_t op, reg_addr_t f1, logic [7:0] low);
		return {op, f1, low};
	endfunction

	function automatic word_t compute_alu(logic [3:0] func, word_t a, word_t b);
		case (func)
			4'h0: return a + b;
			4'h1: return a - b;
			4'h2: return a & b;
			4'h3: return a | b;
			4'h4: return a ^ b;
			4'h5: return {a[14:0], 1'b0};
			4'h6: return {1'b0, a[15:1]};
			default: return b;
		endcase
	endfunction

	// Walk the program by the ISA rules, registers start at zero
	task automatic build_expected();
		word_t  regs [NUM_REGS];
		instr_t ins;
		wb_t    w;
		int     i;
		for (int r = 0; r < NUM_REGS; r++) begin
			regs[r] = '0;
		end
		expected.delete();
		i = 0;
		while (i < prog.size() && prog[i][15:12] != OP_HALT) begin
			ins = prog[i];
			w.valid = 1'b1;
			w.addr = ins[11:8];
			if (ins[15:12] == OP_LI) begin
				w.data = {{8{ins[7]}}, ins[7:0]};
				regs[w.addr] = w.data;
				expected.push_back(w);
			end else if (ins[15:12] == OP_ALU && ins[3] == 1'b0) begin
				w.data = compute_alu(ins[3:0], regs[ins[11:8]], regs[ins[7:4]]);
				regs[w.addr] = w.data;
				expected.push_back(w);
			end else if (ins[15:12] == OP_SKEQ && regs[ins[11:8]] == regs[ins[7:4]]) begin
				// Next word is annulled
				i++;
			end
			i++;
		end
	endtask

	// Write-backs sampled mid-cycle, in program order
	always @(negedge clk) begin
		if (wb.valid) begin
			assert (seen - base < expected.size()) else begin
				$display("Write-back to r%0d at time %0t was not expected", wb.addr, $time);
				wb_errors++;
			end
			if (seen - base < expected.size()) begin
				assert (wb == expected[seen - base]) else begin
					$display("[ERROR] %0t: wb r%0d=%h, expected r%0d=%h", $time, wb.addr,
						wb.data, expected[seen - base].addr, expected[seen - base].data);
					wb_errors++;
				end
			end
			seen++;
		end
	end

	task automatic run_program(input string name);
		int test_errors;
		int start_wb_errors;
		int n;
		int cycles;
		test_errors = 0;
		start_wb_errors = wb_errors;
		n = prog.size();
		build_expected();
		base = seen;
		// Load while reset is held, at least ten cycles
		arst_n = 1'b0;
		for (int k = 0; k < 10 || k < n; k++) begin
			prog_we = (k < n);
			prog_addr = prog_addr_t'(k);
			if (k < n) begin
				prog_data = prog[k];
			end
			@(posedge clk);
			#1;
		end
		prog_we = 1'b0;
		arst_n = 1'b1;
		assert (pc == '0 && !halted && !wb.valid) else begin
			$display("[ERROR] %0t: after reset pc=%h halted=%b wb.valid=%b", $time, pc,
				halted, wb.valid);
			test_errors++;
		end
		cycles = 0;
		while (!halted && cycles < 200) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		assert (halted) else begin
			$display("%s timed out waiting for halted", name);
			test_errors++;
		end
		// Drain plus a margin for stray write-backs
		for (int k = 0; k < 4; k++) begin
			@(posedge clk);
			#1;
		end
		assert (seen - base >= expected.size()) else begin
			$display("%s is missing %0d write-backs", name, expected.size() - (seen - base));
			test_errors++;
		end
		test_errors += wb_errors - start_wb_errors;
		$display("Test %s: %s (%0d errors)", name, test_errors == 0 ? "ok" : "bad", test_errors);
		errors += test_errors;
		tests_run++;
	endtask

	initial begin
		logic [7:0] x;
		logic [7:0] y;
		clk = 1'b0;
		arst_n = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		seed = 32'hbbd5ecf5;
		errors = 0;
		tests_run = 0;
		@(posedge clk);
		#1;

		// Lone halt, reset state and silence
		prog.delete();
		prog.push_back(encode(OP_HALT, 4'd0, 8'h00));
		run_program("reset_halt");

		// Sign extension of both signs
		prog.delete();
		prog.push_back(encode(OP_LI, 4'd1, 8'h85));
		prog.push_back(encode(OP_LI, 4'd2, 8'h7f));
		prog.push_back(encode(OP_LI, 4'd3, 8'h80));
		prog.push_back(encode(OP_LI, 4'd4, 8'hff));
		prog.push_back(encode(OP_LI, 4'd5, 8'h01));
		prog.push_back(encode(OP_HALT, 4'd0, 8'h00));
		run_program("load_imm");

		// r1 by write-through, r2 forwarded from stage B
		prog.delete();
		for (int f = 0; f < 8; f++) begin
			x = 8'($random(seed));
			y = 8'($random(seed));
			prog.push_back(encode(OP_LI, 4'd1, x));
			prog.push_back(encode(OP_LI, 4'd2, y));
			prog.push_back(encode(OP_ALU, 4'd1, {4'd2, 4'(f)}));
		end
		prog.push_back(encode(OP_HALT, 4'd0, 8'h00));
		run_program("alu_forward");

		// Taken, not taken, and an annulled halt
		prog.delete();
		prog.push_back(encode(OP_LI, 4'd1, 8'h05));
		prog.push_back(encode(OP_LI, 4'd2, 8'h05));
		prog.push_back(encode(OP_SKEQ, 4'd1, 8'h20));
		prog.push_back(encode(OP_LI, 4'd3, 8'h01));
		prog.push_back(encode(OP_LI, 4'd4, 8'h07));
		prog.push_back(encode(OP_SKEQ, 4'd1, 8'h40));
		prog.push_back(encode(OP_LI, 4'd5, 8'h02));
		prog.push_back(encode(OP_SKEQ, 4'd1, 8'h20));
		prog.push_back(encode(OP_HALT, 4'd0, 8'h00));
		prog.push_back(encode(OP_LI, 4'd6, 8'h03));
		prog.push_back(encode(OP_HALT, 4'd0, 8'h00));
		run_program("skip");

		// Words after the halt never write
		prog.delete();
		prog.push_back(encode(OP_LI, 4'd7, 8'h09));
		prog.push_back(encode(OP_LI, 4'd8, 8'hf0));
		prog.push_back(encode(OP_HALT, 4'd0, 8'h00));
		prog.push_back(encode(OP_LI, 4'd9, 8'h01));
		prog.push_back(encode(OP_LI, 4'd10, 8'h02));
		run_program("halt");

		errors += cpu_top_i.checker_i.failures;
		$display("Tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
